/* bench/fixed_alu_tb.sv */
`include "fixed_defs.svh"

module fixed_alu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int div_lat = 2 * `RECIP_ITERS + 3;

	typedef struct packed {
		fixed_pkg::alu_req_t req;
		fixed_pkg::alu_rsp_t exp;
		logic [7:0] lat;
		logic poke;
	} row_t;

	logic clk;
	logic rst;
	logic start;
	fixed_pkg::alu_req_t req;
	logic busy;
	logic done;
	fixed_pkg::alu_rsp_t rsp;
	row_t tab[$];
	int errors;
	int issued;
	int done_seen;
	int cycles;
	int limit;

	fixed_alu_top i_dut (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.req   (req),
		.busy  (busy),
		.done  (done),
		.rsp   (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// cycle count for the run limit and a tally of done pulses
	always @(negedge clk) begin
		cycles++;
		if (done)
			done_seen++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, the DUT never finished its requests", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// same signs add with wrap, mixed signs take the larger magnitude minus the smaller
	function automatic fixed_pkg::fix_t model_add(input fixed_pkg::fix_t a,
			input fixed_pkg::fix_t b);
		fixed_pkg::fix_t r;
		if (a.sign == b.sign)
			r = '{sign: a.sign, mag: a.mag + b.mag};
		else if (a.mag >= b.mag)
			r = '{sign: a.sign, mag: a.mag - b.mag};
		else
			r = '{sign: b.sign, mag: b.mag - a.mag};
		r.sign = r.sign && r.mag != 0;
		return r;
	endfunction

	function automatic fixed_pkg::fix_t model_mul(input fixed_pkg::fix_t a,
			input fixed_pkg::fix_t b);
		logic [61:0] p;
		fixed_pkg::fix_t r;
		p = 62'(a.mag) * 62'(b.mag);
		r.mag = p[46:16];
		r.sign = (a.sign ^ b.sign) && r.mag != 0;
		return r;
	endfunction

	// power of two seed, newton steps, then the multiply by the dividend
	function automatic fixed_pkg::alu_rsp_t model_div(input fixed_pkg::fix_t a,
			input fixed_pkg::fix_t b);
		fixed_pkg::alu_rsp_t r;
		fixed_pkg::fix_t x;
		fixed_pkg::fix_t minus_a;
		r = '0;
		x = '{sign: b.sign, mag: '0};
		minus_a = '{sign: ~b.sign, mag: b.mag};
		for (int k = 30; k >= 0; k--) begin
			if (b.mag[k] && x.mag == 0)
				x.mag[30 - k] = 1'b1;
		end
		if (b.mag == 0) begin
			r.result = '{sign: a.sign ^ b.sign, mag: '1};
			r.div_zero = 1'b1;
		end else begin
			repeat (`RECIP_ITERS)
				x = model_mul(x, model_add(fixed_pkg::fix_two, model_mul(minus_a, x)));
			r.result = model_mul(a, x);
		end
		return r;
	endfunction

	task automatic check_fix(input string name, input fixed_pkg::fix_t got,
			input fixed_pkg::fix_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	// low four bits are eq, gt, lt and div_zero
	task automatic check_flags(input fixed_pkg::alu_rsp_t got, input fixed_pkg::alu_rsp_t exp);
		if (got[3:0] !== exp[3:0]) begin
			errors++;
			$display("ERR %0t rsp flags got %b exp %b", $time, got[3:0], exp[3:0]);
		end
	endtask

	task automatic check_lat(input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("ERR %0t done latency got %0d exp %0d", $time, got, exp);
		end
	endtask

	task automatic add_row(input fixed_pkg::alu_op_e op, input fixed_pkg::fix_t a,
			input fixed_pkg::fix_t b, input fixed_pkg::alu_rsp_t exp, input int lat,
			input logic poke);
		row_t row;
		row.req = '{op: op, a: a, b: b};
		row.exp = exp;
		row.lat = 8'(lat);
		row.poke = poke;
		tab.push_back(row);
	endtask

	task automatic add_div(input fixed_pkg::fix_t a, input fixed_pkg::fix_t b,
			input logic poke);
		add_row(fixed_pkg::OP_DIV, a, b, model_div(a, b), b.mag == 0 ? 3 : div_lat, poke);
	endtask

	task automatic run_op(input row_t row);
		fixed_pkg::alu_req_t other;
		int lat;
		other = '{op: fixed_pkg::OP_ADD, a: row.req.b, b: row.req.a};
		lat = 0;
		@(posedge clk);
		start <= 1'b1;
		req <= row.req;
		issued++;
		do begin
			@(posedge clk);
			lat++;
			// second start in the middle of a divide
			start <= row.poke && lat == 3;
			req <= other;
			@(negedge clk);
			if (!done && !busy) begin
				errors++;
				$display("ERR %0t busy got %b exp 1", $time, busy);
			end
		end while (!done);
		check_lat(lat, row.lat);
		check_fix("rsp.result", rsp.result, row.exp.result);
		check_flags(rsp, row.exp);
		if (row.req.op == fixed_pkg::OP_CMP && $countones(rsp[3:1]) != 1) begin
			errors++;
			$display("compare did not set exactly one of eq, gt and lt");
		end
	endtask

	initial begin
		logic [31:0] rs;
		logic [31:0] ra;
		rst = 1'b1;
		start = 1'b0;
		req = '0;
		// add and subtract, mixed signs, cancellation and wrap
		add_row(fixed_pkg::OP_ADD, 32'h00018000, 32'h80004000, {32'h00014000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_ADD, 32'h80020000, 32'h00008000, {32'h80018000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_ADD, 32'h00030000, 32'h80030000, {32'h00000000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_SUB, 32'h80010000, 32'h80010000, {32'h00000000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_ADD, 32'h7fff0000, 32'h00020000, {32'h00010000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_ADD, 32'hffff0000, 32'h80018000, {32'h80008000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_SUB, 32'h00008000, 32'h00024000, {32'h8001c000, 4'b0000}, 2, 0);
		// multiply with truncation and zero operands
		add_row(fixed_pkg::OP_MUL, 32'h00018000, 32'h80028000, {32'h8003c000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_MUL, 32'h80000003, 32'h00008000, {32'h80000001, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_MUL, 32'h80000001, 32'h00008000, {32'h00000000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_MUL, 32'h80000000, 32'h00030000, {32'h00000000, 4'b0000}, 2, 0);
		add_row(fixed_pkg::OP_MUL, 32'h8000c000, 32'h8000c000, {32'h00009000, 4'b0000}, 2, 0);
		// compare
		add_row(fixed_pkg::OP_CMP, 32'h00010000, 32'h00020000, {32'h00000000, 4'b0010}, 2, 0);
		add_row(fixed_pkg::OP_CMP, 32'h80010000, 32'h80020000, {32'h00000000, 4'b0100}, 2, 0);
		add_row(fixed_pkg::OP_CMP, 32'h00000000, 32'h80000000, {32'h00000000, 4'b1000}, 2, 0);
		add_row(fixed_pkg::OP_CMP, 32'h80008000, 32'h00004000, {32'h00000000, 4'b0010}, 2, 0);
		// divide with a zero dividend and zero divisors of both signs
		add_row(fixed_pkg::OP_DIV, 32'h00000000, 32'h00030000, {32'h00000000, 4'b0000},
			div_lat, 0);
		add_row(fixed_pkg::OP_DIV, 32'h00010000, 32'h80000000, {32'hffffffff, 4'b0001}, 3, 0);
		add_row(fixed_pkg::OP_DIV, 32'h80020000, 32'h80000000, {32'h7fffffff, 4'b0001}, 3, 0);
		add_div(32'h00030000, 32'h00018000, 1'b1);
		add_div(32'h80078000, 32'h00020000, 1'b0);
		add_div(fixed_pkg::fix_one, 32'h0000199a, 1'b0);
		add_div(32'h00640000, 32'h80030000, 1'b1);
		rs = 32'h3a0e;
		repeat (8) begin
			rs = xorshift(rs);
			ra = rs;
			rs = xorshift(rs);
			// random shift spreads the divisor over many binades
			add_div(ra, {rs[31], rs[30:0] >> rs[4:0]}, 1'b0);
		end
		// one divide per row at most, plus reset and drain
		limit = tab.size() * (div_lat + 2) + 20;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (busy !== 1'b0 || done !== 1'b0) begin
			errors++;
			$display("ERR %0t busy,done got %b,%b exp 0,0", $time, busy, done);
		end
		check_fix("rsp.result", rsp.result, '0);
		check_flags(rsp, '0);
		foreach (tab[i])
			run_op(tab[i]);
		repeat (4) @(negedge clk);
		if (done_seen != issued) begin
			errors++;
			$display("counted %0d done pulses for %0d requests", done_seen, issued);
		end
		$display("%0d errors in %0d requests", errors, issued);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* include/fixed_defs.svh */
`ifndef FIXED_DEFS_SVH
`define FIXED_DEFS_SVH

// sign-magnitude word, one sign bit on top
`define FIX_W 32

// fraction bits of the Q16.16 magnitude
`define FIX_FRAC 16

// newton steps for the reciprocal
`define RECIP_ITERS 5

`endif

/* list.f */
+incdir+include
source/fixed_pkg.sv
source/sm_adder.sv
source/sm_multiplier.sv
source/sm_compare.sv
source/recip_seed.sv
source/fixed_alu_ctrl.sv
source/fixed_alu_top.sv
bench/fixed_alu_tb.sv

/* source/fixed_alu_ctrl.sv */
`include "fixed_defs.svh"

module fixed_alu_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  fixed_pkg::alu_req_t req,
	output logic busy,
	output logic done,
	output fixed_pkg::alu_rsp_t rsp,
	output fixed_pkg::fix_t add_a,
	output fixed_pkg::fix_t add_b,
	input  fixed_pkg::fix_t add_sum,
	output fixed_pkg::fix_t mul_a,
	output fixed_pkg::fix_t mul_b,
	input  fixed_pkg::fix_t mul_prod,
	input  logic cmp_eq,
	input  logic cmp_gt,
	input  logic cmp_lt,
	input  fixed_pkg::fix_t seed,
	input  logic seed_zero
);
	localparam int iter_w = $clog2(`RECIP_ITERS + 1);

	typedef enum logic [2:0] {
		st_idle,
		st_exec,
		st_seed,
		st_step_mul,
		st_step_upd,
		st_final
	} state_e;

	state_e state;
	logic [iter_w-1:0] iter;

	fixed_pkg::alu_req_t req_q;
	fixed_pkg::fix_t minus_a;
	fixed_pkg::fix_t x;
	fixed_pkg::fix_t t;

	assign busy = (state != st_idle);

	// adder carries the latched operands except during the newton update,
	// so the comparator and seed logic see them as well
	always_comb begin
		add_a = req_q.a;
		add_b = req_q.b;
		if (state == st_step_upd) begin
			add_a = fixed_pkg::fix_two;
			add_b = t;
		end else if (state == st_exec && req_q.op == fixed_pkg::OP_SUB) begin
			add_b.sign = ~req_q.b.sign;
		end
	end

	always_comb begin
		mul_a = req_q.a;
		mul_b = req_q.b;
		case (state)
			st_step_mul: begin
				// t = -d * x
				mul_a = minus_a;
				mul_b = x;
			end
			st_step_upd: begin
				// x * (2 + t)
				mul_a = x;
				mul_b = add_sum;
			end
			st_final: begin
				mul_b = x;
			end
			default: begin
			end
		endcase
	end

	// request is captured on the start cycle itself
	always_ff @(posedge clk) begin
		if (start && state == st_idle) begin
			req_q <= req;
			minus_a <= '{sign: ~req.b.sign, mag: req.b.mag};
		end
		case (state)
			st_seed: x <= seed;
			st_step_mul: t <= mul_prod;
			st_step_upd: x <= mul_prod;
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			iter <= '0;
			done <= 1'b0;
			rsp <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						if (req.op == fixed_pkg::OP_DIV)
							state <= st_seed;
						else
							state <= st_exec;
					end
				end
				st_exec: begin
					rsp <= '0;
					case (req_q.op)
						fixed_pkg::OP_ADD, fixed_pkg::OP_SUB: rsp.result <= add_sum;
						fixed_pkg::OP_MUL: rsp.result <= mul_prod;
						fixed_pkg::OP_CMP: begin
							rsp.eq <= cmp_eq;
							rsp.gt <= cmp_gt;
							rsp.lt <= cmp_lt;
						end
						default: begin
						end
					endcase
					done <= 1'b1;
					state <= st_idle;
				end
				st_seed: begin
					iter <= '0;
					// zero divisor goes straight to the saturated result
					if (seed_zero)
						state <= st_final;
					else
						state <= st_step_mul;
				end
				st_step_mul: begin
					state <= st_step_upd;
				end
				st_step_upd: begin
					if (iter == iter_w'(`RECIP_ITERS - 1)) begin
						state <= st_final;
					end else begin
						iter <= iter + 1'b1;
						state <= st_step_mul;
					end
				end
				st_final: begin
					rsp <= '0;
					if (seed_zero) begin
						rsp.result.sign <= req_q.a.sign ^ req_q.b.sign;
						rsp.result.mag <= '1;
						rsp.div_zero <= 1'b1;
					end else begin
						rsp.result <= mul_prod;
					end
					done <= 1'b1;
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* source/fixed_alu_top.sv */
module fixed_alu_top (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  fixed_pkg::alu_req_t req,
	output logic busy,
	output logic done,
	output fixed_pkg::alu_rsp_t rsp
);
	fixed_pkg::fix_t add_a;
	fixed_pkg::fix_t add_b;
	fixed_pkg::fix_t add_sum;
	fixed_pkg::fix_t mul_a;
	fixed_pkg::fix_t mul_b;
	fixed_pkg::fix_t mul_prod;
	fixed_pkg::fix_t seed;
	logic cmp_eq;
	logic cmp_gt;
	logic cmp_lt;
	logic seed_zero;

	fixed_alu_ctrl i_ctrl (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.req       (req),
		.busy      (busy),
		.done      (done),
		.rsp       (rsp),
		.add_a     (add_a),
		.add_b     (add_b),
		.add_sum   (add_sum),
		.mul_a     (mul_a),
		.mul_b     (mul_b),
		.mul_prod  (mul_prod),
		.cmp_eq    (cmp_eq),
		.cmp_gt    (cmp_gt),
		.cmp_lt    (cmp_lt),
		.seed      (seed),
		.seed_zero (seed_zero)
	);

	sm_adder i_adder (
		.a   (add_a),
		.b   (add_b),
		.sum (add_sum)
	);

	sm_multiplier i_mult (
		.a    (mul_a),
		.b    (mul_b),
		.prod (mul_prod)
	);

	// adder operands hold the latched request outside the newton update
	sm_compare i_cmp (
		.a  (add_a),
		.b  (add_b),
		.eq (cmp_eq),
		.gt (cmp_gt),
		.lt (cmp_lt)
	);

	recip_seed i_seed (
		.d    (add_b),
		.seed (seed),
		.zero (seed_zero)
	);

endmodule

/* source/fixed_pkg.sv */
`include "fixed_defs.svh"

package fixed_pkg;

	typedef struct packed {
		logic sign;
		logic [`FIX_W-2:0] mag;
	} fix_t;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_MUL = 3'd2,
		OP_DIV = 3'd3,
		OP_CMP = 3'd4
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		fix_t a;
		fix_t b;
	} alu_req_t;

	typedef struct packed {
		fix_t result;
		logic eq;
		logic gt;
		logic lt;
		logic div_zero;
	} alu_rsp_t;

	// 1.0 and 2.0 in Q16.16
	localparam fix_t fix_one = '{
		sign: 1'b0,
		mag: (`FIX_W-1)'(1) << `FIX_FRAC
	};
	localparam fix_t fix_two = '{
		sign: 1'b0,
		mag: (`FIX_W-1)'(2) << `FIX_FRAC
	};

endpackage

/* source/recip_seed.sv */
`include "fixed_defs.svh"

module recip_seed (
	input  fixed_pkg::fix_t d,
	output fixed_pkg::fix_t seed,
	output logic zero
);
	localparam int mag_w = `FIX_W - 1;
	localparam int idx_w = $clog2(mag_w);

	logic [idx_w-1:0] msb;

	// leading one, highest set bit wins
	always_comb begin
		msb = '0;
		for (int i = 0; i < mag_w; i++) begin
			if (d.mag[i]) begin
				msb = idx_w'(i);
			end
		end
	end

	// one bit mirrored around the top of the magnitude
	assign seed.mag = {{(mag_w-1){1'b0}}, 1'b1} << (mag_w - 1 - msb);
	assign seed.sign = d.sign;

	assign zero = ~|d.mag;

endmodule

/* source/sm_adder.sv */
module sm_adder (
	input  fixed_pkg::fix_t a,
	input  fixed_pkg::fix_t b,
	output fixed_pkg::fix_t sum
);
	fixed_pkg::fix_t raw;

	always_comb begin
		if (a.sign == b.sign) begin
			// same sign, magnitudes wrap at 31 bits
			raw.mag = a.mag + b.mag;
			raw.sign = a.sign;
		end else if (a.mag >= b.mag) begin
			raw.mag = a.mag - b.mag;
			raw.sign = a.sign;
		end else begin
			raw.mag = b.mag - a.mag;
			raw.sign = b.sign;
		end
	end

	// no negative zero out of the adder
	assign sum.mag = raw.mag;
	assign sum.sign = raw.sign & (|raw.mag);

endmodule

/* source/sm_compare.sv */
module sm_compare (
	input  fixed_pkg::fix_t a,
	input  fixed_pkg::fix_t b,
	output logic eq,
	output logic gt,
	output logic lt
);
	always_comb begin
		eq = 1'b0;
		gt = 1'b0;
		lt = 1'b0;
		if (a.mag == '0 && b.mag == '0) begin
			// +0 and -0 are the same value
			eq = 1'b1;
		end else if (a.sign != b.sign) begin
			gt = ~a.sign;
			lt = a.sign;
		end else if (a.mag == b.mag) begin
			eq = 1'b1;
		end else if (a.sign) begin
			// both negative, order flips
			gt = a.mag < b.mag;
			lt = a.mag > b.mag;
		end else begin
			gt = a.mag > b.mag;
			lt = a.mag < b.mag;
		end
	end

endmodule

/* source/sm_multiplier.sv */
`include "fixed_defs.svh"

module sm_multiplier (
	input  fixed_pkg::fix_t a,
	input  fixed_pkg::fix_t b,
	output fixed_pkg::fix_t prod
);
	logic [2*(`FIX_W-1)-1:0] full;
	logic [`FIX_W-2:0] mag;

	assign full = a.mag * b.mag;

	// keep the Q16.16 window, low fraction bits are dropped
	assign mag = full[`FIX_W-2+`FIX_FRAC:`FIX_FRAC];

	assign prod.mag = mag;
	assign prod.sign = (a.sign ^ b.sign) & (|mag);

endmodule
